/* list.f */
riscv_pkg.sv
mem_bus_if.sv
hazard_unit.sv
mem_port.sv
mem_arbiter.sv
pipe_ctrl_top.sv
tb_pipe_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pipe_ctrl
RTL_TOP   ?= pipe_ctrl_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

RTL  = riscv_pkg.sv mem_bus_if.sv hazard_unit.sv mem_port.sv mem_arbiter.sv pipe_ctrl_top.sv
SRCS = $(RTL) tb_pipe_ctrl.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_pipe_ctrl.sv */
// Random checks of the stall and flush control against a reference model and shadow memory.
// The memory model acks 1 to 5 cycles after it first sees a request.
module tb_pipe_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import riscv_pkg::*;

    logic         CLK;
    logic         RSTn;
    branch_e      branch;
    mem_ctrl_t    ex_mem_ctrl;
    reg_idx_t     ex_mem_rd, dec_ex_rs1, dec_ex_rs2;
    hazard_ctrl_e pc_reg, if_dec, dec_ex, ex_mem, mem_wb;
    logic         instr_mux_sel;
    logic         fetch_start, fetch_done, data_start, data_we, data_done;
    word_t        fetch_addr, fetch_rdata, data_addr, data_wdata, data_rdata;
    logic         mem_req, mem_we;
    word_t        mem_addr, mem_wdata;
    logic         mem_ack = 1'b0;
    word_t        mem_rdata = '0;

    int unsigned  errors;
    int unsigned  checks;
    int unsigned  tests;
    bit           timed_out;
    word_t        shadow [word_t];
    word_t        mem_array [word_t];
    // bus addresses in the order the memory first saw them
    word_t        bus_log [$];
    bit           in_xfer = 1'b0;
    int unsigned  wait_left = 0;

    pipe_ctrl_top DUT (.*);

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    // untouched words read back a pattern built from the whole address
    function automatic word_t fill_word(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6b3d_91e5;
    endfunction

    function automatic word_t expected_word(input word_t addr);
        return shadow.exists(addr) ? shadow[addr] : fill_word(addr);
    endfunction

    // memory model, one-cycle ack after a random latency
    always @(posedge CLK) begin
        #1;
        if (!RSTn || mem_ack) begin
            mem_ack = 1'b0;
            in_xfer = 1'b0;
        end else if (mem_req) begin
            if (!in_xfer) begin
                in_xfer   = 1'b1;
                wait_left = $urandom_range(5, 1);
                bus_log.push_back(mem_addr);
            end else if (wait_left > 1) begin
                wait_left--;
            end else begin
                mem_ack = 1'b1;
                if (mem_we) begin
                    mem_array[mem_addr] = mem_wdata;
                end else begin
                    mem_rdata = mem_array.exists(mem_addr) ? mem_array[mem_addr]
                                                           : fill_word(mem_addr);
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic check_ctrl(input string name, input hazard_ctrl_e got,
                              input hazard_ctrl_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_frozen();
        check_ctrl("pc_reg", pc_reg, stall);
        check_ctrl("if_dec", if_dec, stall);
        check_ctrl("dec_ex", dec_ex, stall);
        check_ctrl("ex_mem", ex_mem, stall);
        check_ctrl("mem_wb", mem_wb, stall);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout: %s did not arrive within 200 cycles", what);
    endtask

    task automatic report_test(input string name, input int unsigned errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d failing checks", name, errors - errs_before);
        end
    endtask

    task automatic test_reset();
        int unsigned e0;
        e0 = errors;
        @(negedge CLK);
        check_ctrl("pc_reg", pc_reg, enable);
        check_ctrl("if_dec", if_dec, enable);
        check_ctrl("dec_ex", dec_ex, enable);
        check_ctrl("ex_mem", ex_mem, enable);
        check_ctrl("mem_wb", mem_wb, enable);
        check_bit("mem_req", mem_req, 1'b0);
        check_bit("fetch_done", fetch_done, 1'b0);
        check_bit("data_done", data_done, 1'b0);
        check_bit("instr_mux_sel", instr_mux_sel, 1'b0);
        report_test("reset", e0);
    endtask

    task automatic test_hazard();
        int unsigned  e0;
        logic [31:0]  r;
        logic         lu;
        hazard_ctrl_e e_pc, e_ifd, e_dex;
        e0 = errors;
        for (int i = 0; i < 80; i++) begin
            next_cycle();
            r = $urandom;
            // small register range so conflicts and x0 come up often
            ex_mem_ctrl = mem_ctrl_t'(r[1:0]);
            branch      = branch_e'(r[2]);
            ex_mem_rd   = {3'b000, r[4:3]};
            dec_ex_rs1  = {3'b000, r[6:5]};
            dec_ex_rs2  = {3'b000, r[8:7]};
            lu = ex_mem_ctrl.mem_en && (ex_mem_ctrl.dir == read) && (ex_mem_rd != 5'd0) &&
                 ((ex_mem_rd == dec_ex_rs1) || (ex_mem_rd == dec_ex_rs2));
            e_pc  = (lu || branch == jump) ? stall : enable;
            e_ifd = lu ? stall : ((branch == jump) ? flush : enable);
            e_dex = lu ? flush : enable;
            @(negedge CLK);
            check_ctrl("pc_reg", pc_reg, e_pc);
            check_ctrl("if_dec", if_dec, e_ifd);
            check_ctrl("dec_ex", dec_ex, e_dex);
            check_ctrl("ex_mem", ex_mem, enable);
            check_ctrl("mem_wb", mem_wb, enable);
            check_bit("instr_mux_sel", instr_mux_sel, 1'b0);
        end
        next_cycle();
        branch      = no_jump;
        ex_mem_ctrl = '0;
        report_test("branch_load_use", e0);
    endtask

    task automatic do_fetch(input word_t addr);
        word_t exp;
        int    cyc;
        int    mux_cnt;
        bit    seen;
        exp     = expected_word(addr);
        cyc     = 0;
        mux_cnt = 0;
        seen    = 1'b0;
        next_cycle();
        fetch_start = 1'b1;
        fetch_addr  = addr;
        while (!seen && cyc < 200) begin
            @(negedge CLK);
            if (cyc >= 2) begin
                check_frozen();
            end
            if (instr_mux_sel) begin
                mux_cnt++;
            end
            if (fetch_done) begin
                seen = 1'b1;
                check_word("fetch_rdata", fetch_rdata, exp);
            end
            next_cycle();
            fetch_start = 1'b0;
            cyc++;
        end
        if (!seen) begin
            report_timeout("fetch_done");
        end else begin
            // select pulse trails done by one cycle
            for (int i = 0; i < 2; i++) begin
                @(negedge CLK);
                if (instr_mux_sel) begin
                    mux_cnt++;
                end
                next_cycle();
            end
            checks++;
            if (mux_cnt != 1) begin
                errors++;
                $display("instr_mux_sel pulsed %0d times for one fetch", mux_cnt);
            end
        end
    endtask

    task automatic do_data(input logic we, input word_t addr, input word_t wdata,
                           input bit extra);
        word_t exp;
        int    cyc;
        int    dones;
        exp   = expected_word(addr);
        cyc   = 0;
        dones = 0;
        if (we) begin
            shadow[addr] = wdata;
        end
        next_cycle();
        data_start = 1'b1;
        data_we    = we;
        data_addr  = addr;
        data_wdata = wdata;
        while (dones == 0 && cyc < 200) begin
            @(negedge CLK);
            if (data_done) begin
                dones++;
                if (!we) begin
                    check_word("data_rdata", data_rdata, exp);
                end
            end
            next_cycle();
            // second start while the first access is pending
            if (extra && cyc == 0) begin
                data_we   = 1'b1;
                data_addr = ~addr;
            end else begin
                data_start = 1'b0;
            end
            cyc++;
        end
        if (dones == 0) begin
            report_timeout("data_done");
        end else begin
            for (int i = 0; i < 8; i++) begin
                @(negedge CLK);
                if (data_done) begin
                    dones++;
                end
                next_cycle();
            end
            checks++;
            if (dones != 1) begin
                errors++;
                $display("data port gave %0d done pulses for one access", dones);
            end
        end
    endtask

    task automatic test_fetch();
        int unsigned e0;
        e0 = errors;
        for (int i = 0; i < 10 && !timed_out; i++) begin
            do_fetch($urandom & 32'h7fff_fffc);
        end
        report_test("fetch", e0);
    endtask

    task automatic test_data();
        int unsigned e0;
        word_t       addrs [6];
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            addrs[i] = 32'h8000_0000 | ($urandom & 32'h7fff_fffc);
        end
        for (int i = 0; i < 6 && !timed_out; i++) begin
            do_data(1'b1, addrs[i], $urandom, i == 2);
        end
        for (int i = 0; i < 6 && !timed_out; i++) begin
            do_data(1'b0, addrs[i], '0, i == 4);
        end
        report_test("data_access", e0);
    endtask

    task automatic test_arbitration();
        int unsigned e0;
        logic [31:0] r;
        word_t       f_addr, d_addr, d_wdata, f_exp, d_exp;
        logic        d_we;
        int          cyc;
        bit          f_seen, d_seen;
        e0 = errors;
        for (int i = 0; i < 6 && !timed_out; i++) begin
            r       = $urandom;
            d_we    = r[0];
            f_addr  = $urandom & 32'h7fff_fffc;
            d_addr  = 32'h8000_0000 | ($urandom & 32'h7fff_fffc);
            d_wdata = $urandom;
            f_exp   = expected_word(f_addr);
            d_exp   = expected_word(d_addr);
            if (d_we) begin
                shadow[d_addr] = d_wdata;
            end
            bus_log.delete();
            next_cycle();
            fetch_start = 1'b1;
            fetch_addr  = f_addr;
            data_start  = 1'b1;
            data_we     = d_we;
            data_addr   = d_addr;
            data_wdata  = d_wdata;
            f_seen = 1'b0;
            d_seen = 1'b0;
            cyc    = 0;
            while (!(f_seen && d_seen) && cyc < 200) begin
                @(negedge CLK);
                if (fetch_done) begin
                    f_seen = 1'b1;
                    check_word("fetch_rdata", fetch_rdata, f_exp);
                end
                if (data_done) begin
                    d_seen = 1'b1;
                    if (!d_we) begin
                        check_word("data_rdata", data_rdata, d_exp);
                    end
                end
                next_cycle();
                fetch_start = 1'b0;
                data_start  = 1'b0;
                cyc++;
            end
            if (!(f_seen && d_seen)) begin
                report_timeout("fetch_done and data_done");
            end else begin
                check_word("mem_addr", (bus_log.size() != 0) ? bus_log[0] : word_t'(0), d_addr);
                repeat (2) next_cycle();
            end
        end
        report_test("arbitration", e0);
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        tests       = 0;
        timed_out   = 1'b0;
        RSTn        = 1'b0;
        branch      = no_jump;
        ex_mem_ctrl = '0;
        ex_mem_rd   = '0;
        dec_ex_rs1  = '0;
        dec_ex_rs2  = '0;
        fetch_start = 1'b0;
        fetch_addr  = '0;
        data_start  = 1'b0;
        data_we     = 1'b0;
        data_addr   = '0;
        data_wdata  = '0;
        void'($urandom(52603));
        repeat (4) @(posedge CLK);
        #1;
        RSTn = 1'b1;
        test_reset();
        if (!timed_out) test_hazard();
        if (!timed_out) test_fetch();
        if (!timed_out) test_data();
        if (!timed_out) test_arbitration();
        $display("%0d tests, %0d checks, %0d failing", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* pipe_ctrl_top.sv */
// Stall and flush control with the fetch and data requesters sharing one memory bus.
// Fetch never writes. Memory must take at least one cycle before ack.
module pipe_ctrl_top (
    input  logic                    CLK,
    input  logic                    RSTn,
    input  riscv_pkg::branch_e      branch,
    input  riscv_pkg::mem_ctrl_t    ex_mem_ctrl,
    input  riscv_pkg::reg_idx_t     ex_mem_rd,
    input  riscv_pkg::reg_idx_t     dec_ex_rs1,
    input  riscv_pkg::reg_idx_t     dec_ex_rs2,
    output riscv_pkg::hazard_ctrl_e pc_reg,
    output riscv_pkg::hazard_ctrl_e if_dec,
    output riscv_pkg::hazard_ctrl_e dec_ex,
    output riscv_pkg::hazard_ctrl_e ex_mem,
    output riscv_pkg::hazard_ctrl_e mem_wb,
    output logic                    instr_mux_sel,
    input  logic                    fetch_start,
    input  riscv_pkg::word_t        fetch_addr,
    output logic                    fetch_done,
    output riscv_pkg::word_t        fetch_rdata,
    input  logic                    data_start,
    input  logic                    data_we,
    input  riscv_pkg::word_t        data_addr,
    input  riscv_pkg::word_t        data_wdata,
    output logic                    data_done,
    output riscv_pkg::word_t        data_rdata,
    output logic                    mem_req,
    output logic                    mem_we,
    output riscv_pkg::word_t        mem_addr,
    output riscv_pkg::word_t        mem_wdata,
    input  riscv_pkg::word_t        mem_rdata,
    input  logic                    mem_ack
);
    import riscv_pkg::*;

    logic instr_busy;
    logic data_busy;
    logic instr_allow;
    logic data_allow;

    mem_bus_if instr_bus ();
    mem_bus_if data_bus ();

    hazard_unit u_hazard (
        .CLK(CLK), .RSTn(RSTn), .branch(branch), .ex_mem_ctrl(ex_mem_ctrl),
        .ex_mem_rd(ex_mem_rd), .dec_ex_rs1(dec_ex_rs1), .dec_ex_rs2(dec_ex_rs2),
        .instr_busy(instr_busy), .data_busy(data_busy), .instr_allow(instr_allow),
        .data_allow(data_allow), .instr_mux_sel(instr_mux_sel), .pc_reg(pc_reg),
        .if_dec(if_dec), .dec_ex(dec_ex), .ex_mem(ex_mem), .mem_wb(mem_wb)
    );

    // instruction fetch, read only
    mem_port u_fetch_port (
        .CLK(CLK), .RSTn(RSTn), .start(fetch_start), .allow(instr_allow),
        .we(read), .addr(fetch_addr), .wdata(word_t'(0)), .busy(instr_busy),
        .done(fetch_done), .rdata(fetch_rdata), .bus(instr_bus)
    );

    mem_port u_data_port (
        .CLK(CLK), .RSTn(RSTn), .start(data_start), .allow(data_allow),
        .we(data_we), .addr(data_addr), .wdata(data_wdata), .busy(data_busy),
        .done(data_done), .rdata(data_rdata), .bus(data_bus)
    );

    mem_arbiter u_arbiter (
        .CLK(CLK), .RSTn(RSTn), .mem_rdata(mem_rdata), .mem_ack(mem_ack),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .instr_bus(instr_bus), .data_bus(data_bus)
    );

endmodule

/* mem_arbiter.sv */
// Data requester wins each new arbitration. The grant stays locked until the memory acks.
module mem_arbiter (
    input  logic             CLK,
    input  logic             RSTn,
    input  riscv_pkg::word_t mem_rdata,
    input  logic             mem_ack,
    output logic             mem_req,
    output logic             mem_we,
    output riscv_pkg::word_t mem_addr,
    output riscv_pkg::word_t mem_wdata,
    mem_bus_if.arbiter       instr_bus,
    mem_bus_if.arbiter       data_bus
);
    import riscv_pkg::*;

    logic lock_q;
    // owner of the locked transfer is data when high
    logic own_data_q;
    logic grant_data;

    always_comb begin
        if (lock_q) begin
            grant_data = own_data_q;
        end else begin
            grant_data = data_bus.req;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            lock_q     <= 1'b0;
            own_data_q <= 1'b0;
        end else if (mem_ack) begin
            lock_q <= 1'b0;
        end else if (!lock_q && mem_req) begin
            lock_q     <= 1'b1;
            own_data_q <= grant_data;
        end
    end

    assign mem_req   = grant_data ? data_bus.req   : instr_bus.req;
    assign mem_we    = grant_data ? data_bus.we    : instr_bus.we;
    assign mem_addr  = grant_data ? data_bus.addr  : instr_bus.addr;
    assign mem_wdata = grant_data ? data_bus.wdata : instr_bus.wdata;

    // read word goes to both but only the owner sees ack
    assign instr_bus.rdata = mem_rdata;
    assign data_bus.rdata  = mem_rdata;
    assign instr_bus.ack   = mem_ack && mem_req && !grant_data;
    assign data_bus.ack    = mem_ack && mem_req && grant_data;

    a_one_ack: assert property (@(posedge CLK) disable iff (!RSTn)
        !(instr_bus.ack && data_bus.ack));

    // a granted request keeps its owner until the memory acks
    a_owner_held: assert property (@(posedge CLK) disable iff (!RSTn)
        mem_req && !mem_ack |=> $stable(grant_data));

endmodule

/* mem_port.sv */
// Holds one word access until acknowledged. Starts while busy or disallowed are dropped.
module mem_port (
    input  logic             CLK,
    input  logic             RSTn,
    input  logic             start,
    input  logic             allow,
    input  logic             we,
    input  riscv_pkg::word_t addr,
    input  riscv_pkg::word_t wdata,
    output logic             busy,
    output logic             done,
    output riscv_pkg::word_t rdata,
    mem_bus_if.requester     bus
);
    import riscv_pkg::*;

    logic  busy_q;
    logic  we_q;
    word_t addr_q;
    word_t wdata_q;
    logic  accept;

    assign accept = start && allow && !busy_q;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (bus.ack) begin
            busy_q <= 1'b0;
        end
    end

    // request payload, captured on accept
    always_ff @(posedge CLK) begin
        if (accept) begin
            we_q    <= we;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    assign bus.req   = busy_q;
    assign bus.we    = we_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    assign busy  = busy_q;
    assign done  = busy_q && bus.ack;
    assign rdata = bus.rdata;

    a_req_stable: assert property (@(posedge CLK) disable iff (!RSTn)
        bus.req && !bus.ack |=> $stable(bus.addr) && $stable(bus.we));

endmodule

/* hazard_unit.sv */
// Freezes the whole pipeline while a memory access is outstanding.
// Load-use check ignores x0. Outputs are combinational from state and inputs.
module hazard_unit (
    input  logic                    CLK,
    input  logic                    RSTn,
    input  riscv_pkg::branch_e      branch,
    input  riscv_pkg::mem_ctrl_t    ex_mem_ctrl,
    input  riscv_pkg::reg_idx_t     ex_mem_rd,
    input  riscv_pkg::reg_idx_t     dec_ex_rs1,
    input  riscv_pkg::reg_idx_t     dec_ex_rs2,
    input  logic                    instr_busy,
    input  logic                    data_busy,
    output logic                    instr_allow,
    output logic                    data_allow,
    output logic                    instr_mux_sel,
    output riscv_pkg::hazard_ctrl_e pc_reg,
    output riscv_pkg::hazard_ctrl_e if_dec,
    output riscv_pkg::hazard_ctrl_e dec_ex,
    output riscv_pkg::hazard_ctrl_e ex_mem,
    output riscv_pkg::hazard_ctrl_e mem_wb
);
    import riscv_pkg::*;

    hz_state_e state_q;
    hz_state_e state_d;
    logic      load_use;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            state_q <= issue;
        end else begin
            state_q <= state_d;
        end
    end

    // fetch busy wins over data busy when both are set
    always_comb begin
        case (state_q)
            issue: begin
                if (instr_busy) begin
                    state_d = instr_wait;
                end else if (data_busy) begin
                    state_d = data_wait;
                end else begin
                    state_d = issue;
                end
            end
            instr_wait: state_d = instr_busy ? instr_wait : issue;
            data_wait:  state_d = data_busy ? data_wait : issue;
            default:    state_d = issue;
        endcase
    end

    // load in EX/MEM feeding an operand of the instruction in DEC/EX
    assign load_use = ex_mem_ctrl.mem_en && (ex_mem_ctrl.dir == read) &&
                      (ex_mem_rd != '0) &&
                      ((ex_mem_rd == dec_ex_rs1) || (ex_mem_rd == dec_ex_rs2));

    always_comb begin
        pc_reg      = enable;
        if_dec      = enable;
        dec_ex      = enable;
        ex_mem      = enable;
        mem_wb      = enable;
        instr_allow = 1'b1;
        data_allow  = 1'b1;
        if (state_q == issue) begin
            if (branch == jump) begin
                pc_reg = stall;
                if_dec = flush;
            end
            // bubble into EX overrides the jump flush
            if (load_use) begin
                pc_reg = stall;
                if_dec = stall;
                dec_ex = flush;
            end
        end else begin
            pc_reg      = stall;
            if_dec      = stall;
            dec_ex      = stall;
            ex_mem      = stall;
            mem_wb      = stall;
            instr_allow = 1'b0;
            data_allow  = 1'b0;
        end
    end

    // fetched word selected in the cycle its busy has dropped
    assign instr_mux_sel = (state_q == instr_wait) && !instr_busy;

    // a busy seen while issuing freezes everything from the next cycle
    a_wait_freezes: assert property (@(posedge CLK) disable iff (!RSTn)
        (state_q == issue) && (instr_busy || data_busy) |=>
            (state_q != issue) && (pc_reg == stall) && (if_dec == stall) &&
            (dec_ex == stall) && (ex_mem == stall) && (mem_wb == stall) &&
            !instr_allow && !data_allow);

endmodule

/* mem_bus_if.sv */
// One requester's link to the arbiter. req holds with stable payload until a one-cycle ack.
interface mem_bus_if;
    import riscv_pkg::*;

    logic  req;
    logic  we;
    word_t addr;
    word_t wdata;
    // valid only in the ack cycle
    word_t rdata;
    logic  ack;

    modport requester (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, ack
    );

endinterface

/* riscv_pkg.sv */
// Shared widths, pipeline control codes and FSM encodings of the stall and flush control.
// Every memory access is one 32-bit word. Byte enables are not modelled.
package riscv_pkg;

    // widths fixed by RV32I
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // control code for one pipeline register
    typedef enum logic [1:0] {
        enable = 2'd0,
        stall  = 2'd1,
        flush  = 2'd2
    } hazard_ctrl_e;

    // branch decision coming from fetch
    typedef enum logic {
        no_jump = 1'b0,
        jump    = 1'b1
    } branch_e;

    typedef enum logic {
        read  = 1'b0,
        write = 1'b1
    } mem_dir_e;

    // memory access of the instruction sitting in EX/MEM
    typedef struct packed {
        logic     mem_en;
        mem_dir_e dir;
    } mem_ctrl_t;

    typedef enum logic [1:0] {
        issue      = 2'd0,
        instr_wait = 2'd1,
        data_wait  = 2'd2
    } hz_state_e;

endpackage
